//--- ip_mux_pkg.sv
// shared widths and the port index type for the two-port ip mux, referenced by scoped name
package ip_mux_pkg;

// number of input ports, the control logic is written for exactly two
localparam int NUM_PORTS = 2;

// index of an input port
typedef logic [$clog2(NUM_PORTS)-1:0] port_sel_t;

// payload byte width
localparam int DATA_W = 8;

// ipv4 address width, used for source and destination
localparam int IP_ADDR_W = 32;

// ip total length field
localparam int IP_LEN_W = 16;

// ip protocol field
localparam int IP_PROTO_W = 8;

endpackage

//--- ip_mux_ctrl.sv
// frame control of the two-port ip mux, tracks the open frame and drives the input ready signals
`timescale 1ns/1ps

module ip_mux_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  ip_mux_pkg::port_sel_t select,
    input  logic                  in_0_hdr_valid,
    input  logic                  in_1_hdr_valid,
    input  logic                  hdr_busy,
    input  logic                  cur_valid,
    input  logic                  cur_last,
    input  logic                  ready_early,
    output logic                  in_0_hdr_ready,
    output logic                  in_1_hdr_ready,
    output logic                  in_0_tready,
    output logic                  in_1_tready,
    output logic                  hdr_load,
    output ip_mux_pkg::port_sel_t cur_sel,
    output logic                  beat_take
);

logic                  frame;
logic                  frame_next;
ip_mux_pkg::port_sel_t sel_next;
logic                  sel_hdr_valid;
logic                  active_tready;
logic                  start;

// header valid of the port named by the select input
assign sel_hdr_valid = (select == 1'b0) ? in_0_hdr_valid : in_1_hdr_valid;

// registered tready of the latched port
assign active_tready = (cur_sel == 1'b0) ? in_0_tready : in_1_tready;

// new frame only when idle, enabled and the header register is free
assign start = ~frame & enable & ~hdr_busy & sel_hdr_valid;
assign hdr_load = start;

assign beat_take = frame & cur_valid & active_tready;

always_comb begin
    frame_next = frame;
    sel_next = cur_sel;
    if (frame) begin
        // close on a taken last byte
        if (beat_take && cur_last) begin
            frame_next = 1'b0;
        end
    end else if (start) begin
        frame_next = 1'b1;
        sel_next = select;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        frame <= 1'b0;
        cur_sel <= '0;
        in_0_hdr_ready <= 1'b0;
        in_1_hdr_ready <= 1'b0;
        in_0_tready <= 1'b0;
        in_1_tready <= 1'b0;
    end else begin
        frame <= frame_next;
        cur_sel <= sel_next;
        // header ready holds while the source keeps valid up
        in_0_hdr_ready <= (in_0_hdr_ready & in_0_hdr_valid) | (start & (select == 1'b0));
        in_1_hdr_ready <= (in_1_hdr_ready & in_1_hdr_valid) | (start & (select == 1'b1));
        // payload ready only on the port that owns the frame
        in_0_tready <= ready_early & frame_next & (sel_next == 1'b0);
        in_1_tready <= ready_early & frame_next & (sel_next == 1'b1);
    end
end

endmodule

//--- ip_hdr_reg.sv
// header datapath of the ip mux, captures the selected port's fields and holds them for output
`timescale 1ns/1ps

module ip_hdr_reg (
    input  logic                                clk,
    input  logic                                rst,
    input  ip_mux_pkg::port_sel_t               select,
    input  logic                                hdr_load,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_0_dest_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_0_source_ip,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0]   in_0_protocol,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]     in_0_length,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_1_dest_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_1_source_ip,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0]   in_1_protocol,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]     in_1_length,
    input  logic                                out_hdr_ready,
    output logic                                out_hdr_valid,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_dest_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_source_ip,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0]   out_protocol,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]     out_length
);

always_ff @(posedge clk) begin
    if (hdr_load) begin
        if (select == 1'b0) begin
            out_dest_ip <= in_0_dest_ip;
            out_source_ip <= in_0_source_ip;
            out_protocol <= in_0_protocol;
            out_length <= in_0_length;
        end else begin
            out_dest_ip <= in_1_dest_ip;
            out_source_ip <= in_1_source_ip;
            out_protocol <= in_1_protocol;
            out_length <= in_1_length;
        end
    end
end

// load only happens while empty, so set wins over clear
always_ff @(posedge clk) begin
    if (rst) begin
        out_hdr_valid <= 1'b0;
    end else if (hdr_load) begin
        out_hdr_valid <= 1'b1;
    end else if (out_hdr_ready) begin
        out_hdr_valid <= 1'b0;
    end
end

endmodule

//--- ip_payload_path.sv
// payload datapath of the ip mux, selects the active port and buffers bytes in a skid register
`timescale 1ns/1ps

module ip_payload_path (
    input  logic                             clk,
    input  logic                             rst,
    input  ip_mux_pkg::port_sel_t            cur_sel,
    input  logic [ip_mux_pkg::DATA_W-1:0]    in_0_tdata,
    input  logic                             in_0_tvalid,
    input  logic                             in_0_tlast,
    input  logic                             in_0_tuser,
    input  logic [ip_mux_pkg::DATA_W-1:0]    in_1_tdata,
    input  logic                             in_1_tvalid,
    input  logic                             in_1_tlast,
    input  logic                             in_1_tuser,
    input  logic                             beat_take,
    input  logic                             out_tready,
    output logic                             cur_valid,
    output logic                             cur_last,
    output logic                             ready_early,
    output logic [ip_mux_pkg::DATA_W-1:0]    out_tdata,
    output logic                             out_tvalid,
    output logic                             out_tlast,
    output logic                             out_tuser
);

logic [ip_mux_pkg::DATA_W-1:0] cur_data;
logic                          cur_user;

logic [ip_mux_pkg::DATA_W-1:0] tmp_tdata;
logic                          tmp_tvalid;
logic                          tmp_tlast;
logic                          tmp_tuser;

// beat of the port that owns the frame
always_comb begin
    if (cur_sel == 1'b0) begin
        cur_data = in_0_tdata;
        cur_valid = in_0_tvalid;
        cur_last = in_0_tlast;
        cur_user = in_0_tuser;
    end else begin
        cur_data = in_1_tdata;
        cur_valid = in_1_tvalid;
        cur_last = in_1_tlast;
        cur_user = in_1_tuser;
    end
end

// room next cycle: output drains, both registers empty,
// or temp stays empty because nothing lands this cycle
assign ready_early = out_tready | (~tmp_tvalid & (~out_tvalid | ~beat_take));

always_ff @(posedge clk) begin
    if (beat_take) begin
        if (out_tready || !out_tvalid) begin
            out_tdata <= cur_data;
            out_tlast <= cur_last;
            out_tuser <= cur_user;
        end else begin
            // output stalled, park the byte
            tmp_tdata <= cur_data;
            tmp_tlast <= cur_last;
            tmp_tuser <= cur_user;
        end
    end else if (out_tready && tmp_tvalid) begin
        out_tdata <= tmp_tdata;
        out_tlast <= tmp_tlast;
        out_tuser <= tmp_tuser;
    end
end

// temp is empty whenever a beat is taken, the ready timing sees to that
always_ff @(posedge clk) begin
    if (rst) begin
        out_tvalid <= 1'b0;
        tmp_tvalid <= 1'b0;
    end else if (beat_take) begin
        if (out_tready || !out_tvalid) begin
            out_tvalid <= 1'b1;
        end else begin
            tmp_tvalid <= 1'b1;
        end
    end else if (out_tready) begin
        out_tvalid <= tmp_tvalid;
        tmp_tvalid <= 1'b0;
    end
end

endmodule

//--- ip_mux_top.sv
// top level of the two-port ip frame mux, connects the control block to the header and payload paths
`timescale 1ns/1ps

module ip_mux_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enable,
    input  ip_mux_pkg::port_sel_t               select,

    input  logic                                in_0_hdr_valid,
    output logic                                in_0_hdr_ready,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_0_dest_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_0_source_ip,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0]   in_0_protocol,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]     in_0_length,
    input  logic [ip_mux_pkg::DATA_W-1:0]       in_0_tdata,
    input  logic                                in_0_tvalid,
    output logic                                in_0_tready,
    input  logic                                in_0_tlast,
    input  logic                                in_0_tuser,

    input  logic                                in_1_hdr_valid,
    output logic                                in_1_hdr_ready,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_1_dest_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]    in_1_source_ip,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0]   in_1_protocol,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]     in_1_length,
    input  logic [ip_mux_pkg::DATA_W-1:0]       in_1_tdata,
    input  logic                                in_1_tvalid,
    output logic                                in_1_tready,
    input  logic                                in_1_tlast,
    input  logic                                in_1_tuser,

    output logic                                out_hdr_valid,
    input  logic                                out_hdr_ready,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_dest_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_source_ip,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0]   out_protocol,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]     out_length,
    output logic [ip_mux_pkg::DATA_W-1:0]       out_tdata,
    output logic                                out_tvalid,
    input  logic                                out_tready,
    output logic                                out_tlast,
    output logic                                out_tuser
);

// control to datapath
logic                  hdr_load;
ip_mux_pkg::port_sel_t cur_sel;
logic                  beat_take;

// datapath to control
logic                  cur_valid;
logic                  cur_last;
logic                  ready_early;

// a pending output header blocks the next capture
ip_mux_ctrl i_ip_mux_ctrl (
    .hdr_busy (out_hdr_valid),
    .*
);

// header fields follow the live select, latched on hdr_load
ip_hdr_reg i_ip_hdr_reg (
    .*
);

ip_payload_path i_ip_payload_path (
    .*
);

endmodule

//--- ip_mux_checker.sv
// protocol assertions for the ip mux, attached to every ip_mux_top through the bind at the end
`timescale 1ns/1ps

module ip_mux_checker (
    input logic                                clk,
    input logic                                rst,
    input ip_mux_pkg::port_sel_t               cur_sel,
    input logic                                in_0_hdr_ready,
    input logic                                in_1_hdr_ready,
    input logic                                in_0_tready,
    input logic                                in_1_tready,
    input logic                                out_hdr_valid,
    input logic                                out_hdr_ready,
    input logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_dest_ip,
    input logic [ip_mux_pkg::IP_ADDR_W-1:0]    out_source_ip,
    input logic [ip_mux_pkg::IP_PROTO_W-1:0]   out_protocol,
    input logic [ip_mux_pkg::IP_LEN_W-1:0]     out_length,
    input logic [ip_mux_pkg::DATA_W-1:0]       out_tdata,
    input logic                                out_tvalid,
    input logic                                out_tready,
    input logic                                out_tlast,
    input logic                                out_tuser
);

// failure counts, read by the testbench for its summary
int reset_fails = 0;
int port_fails = 0;
int payload_fails = 0;
int header_fails = 0;

// one cycle after a reset cycle every ready and valid output is low
assert property (@(posedge clk) rst |=> !(in_0_hdr_ready || in_1_hdr_ready
        || in_0_tready || in_1_tready || out_hdr_valid || out_tvalid))
    else begin
        reset_fails++;
        $error("ready or valid output high after reset");
    end

// only the latched port may see a ready
assert property (@(posedge clk) disable iff (rst)
        (cur_sel == 1'b0) ? !(in_1_tready || in_1_hdr_ready)
                          : !(in_0_tready || in_0_hdr_ready))
    else begin
        port_fails++;
        $error("ready raised on the port that does not own the frame");
    end

// stalled payload output holds its byte
assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
            && $stable(out_tlast) && $stable(out_tuser))
    else begin
        payload_fails++;
        $error("payload output changed while stalled");
    end

// stalled header output holds its fields
assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_dest_ip)
            && $stable(out_source_ip) && $stable(out_protocol) && $stable(out_length))
    else begin
        header_fails++;
        $error("header output changed while stalled");
    end

endmodule

bind ip_mux_top ip_mux_checker i_ip_mux_checker (.*);

//--- ip_mux_tb.sv
// testbench for the ip mux, sends alternating frames under random back-pressure and checks output
`timescale 1ns/1ps

module ip_mux_tb;

localparam int NUM_FRAMES = 8;
// 8 frames of up to 8 bytes at 4 cycles a byte, plus margin
localparam int TIMEOUT_CYCLES = NUM_FRAMES * 8 * 4 + 400;

logic                              clk;
logic                              rst;
logic                              enable;
ip_mux_pkg::port_sel_t             select;

// input ports, indexed by port number
logic                              hdr_valid [2];
logic                              hdr_ready [2];
logic [ip_mux_pkg::IP_ADDR_W-1:0]  dest_ip [2];
logic [ip_mux_pkg::IP_ADDR_W-1:0]  source_ip [2];
logic [ip_mux_pkg::IP_PROTO_W-1:0] protocol [2];
logic [ip_mux_pkg::IP_LEN_W-1:0]   length [2];
logic [ip_mux_pkg::DATA_W-1:0]     tdata [2];
logic                              tvalid [2];
logic                              tready [2];
logic                              tlast [2];
logic                              tuser [2];

logic                              out_hdr_valid;
logic                              out_hdr_ready;
logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_dest_ip;
logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_source_ip;
logic [ip_mux_pkg::IP_PROTO_W-1:0] out_protocol;
logic [ip_mux_pkg::IP_LEN_W-1:0]   out_length;
logic [ip_mux_pkg::DATA_W-1:0]     out_tdata;
logic                              out_tvalid;
logic                              out_tready;
logic                              out_tlast;
logic                              out_tuser;

int          errors = 0;
int          cycles = 0;
int          hdrs_seen = 0;
int          exp_f = 0;
int          exp_k = 0;
int          assert_fails;
logic [16:0] lfsr;

ip_mux_top i_ip_mux_top (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .select         (select),
    .in_0_hdr_valid (hdr_valid[0]),
    .in_0_hdr_ready (hdr_ready[0]),
    .in_0_dest_ip   (dest_ip[0]),
    .in_0_source_ip (source_ip[0]),
    .in_0_protocol  (protocol[0]),
    .in_0_length    (length[0]),
    .in_0_tdata     (tdata[0]),
    .in_0_tvalid    (tvalid[0]),
    .in_0_tready    (tready[0]),
    .in_0_tlast     (tlast[0]),
    .in_0_tuser     (tuser[0]),
    .in_1_hdr_valid (hdr_valid[1]),
    .in_1_hdr_ready (hdr_ready[1]),
    .in_1_dest_ip   (dest_ip[1]),
    .in_1_source_ip (source_ip[1]),
    .in_1_protocol  (protocol[1]),
    .in_1_length    (length[1]),
    .in_1_tdata     (tdata[1]),
    .in_1_tvalid    (tvalid[1]),
    .in_1_tready    (tready[1]),
    .in_1_tlast     (tlast[1]),
    .in_1_tuser     (tuser[1]),
    .out_hdr_valid  (out_hdr_valid),
    .out_hdr_ready  (out_hdr_ready),
    .out_dest_ip    (out_dest_ip),
    .out_source_ip  (out_source_ip),
    .out_protocol   (out_protocol),
    .out_length     (out_length),
    .out_tdata      (out_tdata),
    .out_tvalid     (out_tvalid),
    .out_tready     (out_tready),
    .out_tlast      (out_tlast),
    .out_tuser      (out_tuser)
);

// x^17 + x^14 + 1, one step per random bit
function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
endfunction

function automatic int frame_len(input int f);
    return 3 + f % 5;
endfunction

function automatic logic [7:0] byte_of(input int f, input int k);
    return 8'(16 * f + k);
endfunction

function automatic logic [31:0] dest_ip_of(input int f, input int p);
    return 32'hC0A8_0000 | 32'(p * 256 + f);
endfunction

function automatic logic [31:0] source_ip_of(input int f, input int p);
    return 32'h0A00_0000 | 32'(p * 4096 + f * 16);
endfunction

function automatic logic [7:0] protocol_of(input int p);
    return (p == 0) ? 8'h11 : 8'h06;
endfunction

function automatic logic [15:0] length_of(input int f);
    return 16'(20 + frame_len(f));
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
endtask

task automatic offer_header(input int p, input int f);
    dest_ip[p] = dest_ip_of(f, p);
    source_ip[p] = source_ip_of(f, p);
    protocol[p] = protocol_of(p);
    length[p] = length_of(f);
    hdr_valid[p] = 1'b1;
endtask

// idle port keeps a header and a byte on offer that must never pass
task automatic offer_idle(input int p, input int f);
    offer_header(p, f);
    tdata[p] = 8'h80 | 8'(f);
    tvalid[p] = 1'b1;
    tlast[p] = 1'b1;
    tuser[p] = 1'b1;
endtask

task automatic send_frame(input int f);
    int p;
    p = f % 2;
    select = ip_mux_pkg::port_sel_t'(p);
    offer_idle(1 - p, f);
    offer_header(p, f);
    tvalid[p] = 1'b0;
    // ready is registered, so seen high here means taken at the next edge
    while (!hdr_ready[p]) @(negedge clk);
    @(negedge clk);
    hdr_valid[p] = 1'b0;
    for (int k = 0; k < frame_len(f); k++) begin
        tdata[p] = byte_of(f, k);
        tvalid[p] = 1'b1;
        tlast[p] = (k == frame_len(f) - 1);
        tuser[p] = tlast[p] && (f % 2 == 1);
        while (!tready[p]) @(negedge clk);
        @(negedge clk);
    end
    tvalid[p] = 1'b0;
endtask

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

initial begin
    while (cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    $display("run timed out after %0d cycles before all frames came out", cycles);
    $display("CHECKS FAILED");
    $finish;
end

// output back-pressure and scoreboard, handshakes judged on the falling edge
initial begin
    logic last;
    int   p;
    lfsr = 17'd67056;
    out_tready = 1'b0;
    out_hdr_ready = 1'b0;
    forever begin
        @(negedge clk);
        lfsr = lfsr_step(lfsr);
        out_tready = lfsr[0];
        lfsr = lfsr_step(lfsr);
        out_hdr_ready = lfsr[0];
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            if (hdrs_seen >= NUM_FRAMES) begin
                errors++;
                $display("extra header accepted after the last frame at %0t", $time);
            end else begin
                p = hdrs_seen % 2;
                assert (out_dest_ip == dest_ip_of(hdrs_seen, p))
                    else report_mismatch("out_dest_ip", out_dest_ip, dest_ip_of(hdrs_seen, p));
                assert (out_source_ip == source_ip_of(hdrs_seen, p))
                    else report_mismatch("out_source_ip", out_source_ip,
                                         source_ip_of(hdrs_seen, p));
                assert (out_protocol == protocol_of(p))
                    else report_mismatch("out_protocol", 32'(out_protocol), 32'(protocol_of(p)));
                assert (out_length == length_of(hdrs_seen))
                    else report_mismatch("out_length", 32'(out_length),
                                         32'(length_of(hdrs_seen)));
            end
            hdrs_seen++;
        end
        if (!rst && out_tvalid && out_tready) begin
            if (exp_f >= NUM_FRAMES) begin
                errors++;
                $display("extra payload byte after the last frame at %0t", $time);
            end else begin
                last = (exp_k == frame_len(exp_f) - 1);
                assert (out_tdata == byte_of(exp_f, exp_k))
                    else report_mismatch("out_tdata", 32'(out_tdata),
                                         32'(byte_of(exp_f, exp_k)));
                assert (out_tlast == last)
                    else report_mismatch("out_tlast", 32'(out_tlast), 32'(last));
                assert (out_tuser == (last && exp_f % 2 == 1))
                    else report_mismatch("out_tuser", 32'(out_tuser),
                                         32'(last && exp_f % 2 == 1));
                if (last) begin
                    exp_f++;
                    exp_k = 0;
                end else begin
                    exp_k++;
                end
            end
        end
    end
end

initial begin
    rst = 1'b1;
    enable = 1'b0;
    select = '0;
    offer_idle(0, 0);
    offer_idle(1, 0);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    // headers on offer with enable low, nothing may be captured
    repeat (40) begin
        @(negedge clk);
        assert (!out_hdr_valid)
            else report_mismatch("out_hdr_valid", 32'(out_hdr_valid), 32'h0);
        assert (!hdr_ready[0] && !hdr_ready[1]) else begin
            errors++;
            $display("header ready raised while enable was low at %0t", $time);
        end
    end
    enable = 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
        send_frame(f);
    end
    while (exp_f < NUM_FRAMES || hdrs_seen < NUM_FRAMES) @(negedge clk);
    // quiet time to catch stray output
    repeat (20) @(negedge clk);
    assert_fails = i_ip_mux_top.i_ip_mux_checker.reset_fails
        + i_ip_mux_top.i_ip_mux_checker.port_fails
        + i_ip_mux_top.i_ip_mux_checker.payload_fails
        + i_ip_mux_top.i_ip_mux_checker.header_fails;
    $display("summary: %0d check errors, %0d assertion failures, %0d headers, %0d frames",
             errors, assert_fails, hdrs_seen, exp_f);
    if (errors == 0 && assert_fails == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

endmodule

//--- ip_mux.f
ip_mux_pkg.sv
ip_mux_ctrl.sv
ip_hdr_reg.sv
ip_payload_path.sv
ip_mux_top.sv
ip_mux_checker.sv
ip_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module ip_mux_tb \
    -f ip_mux.f -o ip_mux_sim &&
    ./obj_dir/ip_mux_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
